/* src/pix_pkg.sv */
`default_nettype none

package pix_pkg;

    ////////////////////////////////////////
    // fixed point
    ////////////////////////////////////////

    localparam int FRAC_BITS = 16;

    // signed Q16.16
    typedef logic signed [31:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vec3_t;

    ////////////////////////////////////////
    // block description
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        DIR_UP    = 2'd0,
        DIR_RIGHT = 2'd1,
        DIR_DOWN  = 2'd2,
        DIR_LEFT  = 2'd3
    } dir_e;

    typedef enum logic {
        COLOR_BLUE = 1'b0,
        COLOR_RED  = 1'b1
    } color_e;

    typedef struct packed {
        vec3_t  pos;
        dir_e   dir;
        color_e color;
    } block_t;

    typedef struct packed {
        coord_t r;
        coord_t g;
        coord_t b;
    } rgb_t;

    ////////////////////////////////////////
    // configuration
    ////////////////////////////////////////

    typedef struct packed {
        vec3_t  eye;
        coord_t arrow_half;
        coord_t face_height;
        coord_t intensity;
    } cfg_t;

    typedef logic [2:0] wb_adr_t;

    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        coord_t  dat;
    } wb_req_t;

    typedef struct packed {
        coord_t dat;
        logic   ack;
    } wb_rsp_t;

    localparam wb_adr_t REG_EYE_X       = 3'd0;
    localparam wb_adr_t REG_EYE_Y       = 3'd1;
    localparam wb_adr_t REG_EYE_Z       = 3'd2;
    localparam wb_adr_t REG_ARROW_HALF  = 3'd3;
    localparam wb_adr_t REG_FACE_HEIGHT = 3'd4;
    localparam wb_adr_t REG_INTENSITY   = 3'd5;

    // eye sits above the scene centre, looking down
    localparam cfg_t CFG_RESET = '{
        eye: '{
            x: 32'sd1800 <<< FRAC_BITS,
            y: 32'sd1800 <<< FRAC_BITS,
            z: -(32'sd300 <<< FRAC_BITS)
        },
        arrow_half:  32'sd80 <<< FRAC_BITS,
        face_height: 32'sd200 <<< FRAC_BITS,
        intensity:   32'sd1 <<< FRAC_BITS
    };

endpackage

`default_nettype wire

/* src/pix_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module pix_cfg_regs (
    input  wire logic             clk_in,
    input  wire logic             rst_in,
    input  wire pix_pkg::wb_req_t wb_req,
    output pix_pkg::wb_rsp_t      wb_rsp,
    output pix_pkg::cfg_t         cfg
);

    logic              ack_q;
    pix_pkg::coord_t   rd_dat_q;
    pix_pkg::cfg_t     cfg_q;
    logic              req_go;
    pix_pkg::coord_t   rd_mux;

    // one access per request, ack drops the cycle after it rises
    assign req_go = wb_req.cyc && wb_req.stb && !ack_q;

    ////////////////////////////////////////
    // read decode
    ////////////////////////////////////////

    always_comb begin
        case (wb_req.adr)
            pix_pkg::REG_EYE_X:       rd_mux = cfg_q.eye.x;
            pix_pkg::REG_EYE_Y:       rd_mux = cfg_q.eye.y;
            pix_pkg::REG_EYE_Z:       rd_mux = cfg_q.eye.z;
            pix_pkg::REG_ARROW_HALF:  rd_mux = cfg_q.arrow_half;
            pix_pkg::REG_FACE_HEIGHT: rd_mux = cfg_q.face_height;
            pix_pkg::REG_INTENSITY:   rd_mux = cfg_q.intensity;
            // unmapped
            default:                  rd_mux = '0;
        endcase
    end

    ////////////////////////////////////////
    // register file and ack
    ////////////////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ack_q <= 1'b0;
            cfg_q <= pix_pkg::CFG_RESET;
        end else begin
            ack_q <= req_go;
            if (req_go && wb_req.we) begin
                case (wb_req.adr)
                    pix_pkg::REG_EYE_X:       cfg_q.eye.x       <= wb_req.dat;
                    pix_pkg::REG_EYE_Y:       cfg_q.eye.y       <= wb_req.dat;
                    pix_pkg::REG_EYE_Z:       cfg_q.eye.z       <= wb_req.dat;
                    pix_pkg::REG_ARROW_HALF:  cfg_q.arrow_half  <= wb_req.dat;
                    pix_pkg::REG_FACE_HEIGHT: cfg_q.face_height <= wb_req.dat;
                    pix_pkg::REG_INTENSITY:   cfg_q.intensity   <= wb_req.dat;
                    default: begin
                        // writes to unmapped addresses are dropped
                    end
                endcase
            end
        end
    end

    // read data lines up with ack
    always_ff @(posedge clk_in) begin
        if (req_go) begin
            rd_dat_q <= rd_mux;
        end
    end

    assign wb_rsp = '{dat: rd_dat_q, ack: ack_q};
    assign cfg    = cfg_q;

endmodule

`default_nettype wire

/* src/delay_line.sv */
`timescale 1ns/1ps
`default_nettype none

module delay_line #(
    parameter int WIDTH = 1,
    parameter int DEPTH = 1
) (
    input  wire logic             clk_in,
    input  wire logic             rst_in,
    input  wire logic [WIDTH-1:0] din,
    output logic      [WIDTH-1:0] dout
);

    logic [WIDTH-1:0] pipe [DEPTH];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign dout = pipe[DEPTH-1];

endmodule

`default_nettype wire

/* src/hit_point_calc.sv */
`timescale 1ns/1ps
`default_nettype none

module hit_point_calc (
    input  wire logic            clk_in,
    input  wire logic            rst_in,
    input  wire logic            valid_in,
    input  wire pix_pkg::vec3_t  ray,
    input  wire pix_pkg::coord_t t,
    input  wire pix_pkg::vec3_t  eye,
    output pix_pkg::vec3_t       hit,
    output logic                 hit_valid
);

    // full width Q16.16 product with the extra fraction bits dropped
    function automatic pix_pkg::coord_t mul_q(input pix_pkg::coord_t a,
                                              input pix_pkg::coord_t b);
        logic signed [63:0] wide_a;
        logic signed [63:0] wide_b;
        logic signed [63:0] full;
        wide_a = a;
        wide_b = b;
        full   = wide_a * wide_b;
        return full[pix_pkg::FRAC_BITS +: 32];
    endfunction

    pix_pkg::vec3_t scaled;
    logic           scaled_valid;

    ////////////////////////////////////////
    // valid chain
    ////////////////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            scaled_valid <= 1'b0;
            hit_valid    <= 1'b0;
        end else begin
            scaled_valid <= valid_in;
            hit_valid    <= scaled_valid;
        end
    end

    // stage 1 scale ray by t, stage 2 offset by the eye
    always_ff @(posedge clk_in) begin
        scaled.x <= mul_q(t, ray.x);
        scaled.y <= mul_q(t, ray.y);
        scaled.z <= mul_q(t, ray.z);
        hit.x    <= eye.x + scaled.x;
        hit.y    <= eye.y + scaled.y;
        hit.z    <= eye.z + scaled.z;
    end

endmodule

`default_nettype wire

/* src/arrow_mask.sv */
`timescale 1ns/1ps
`default_nettype none

module arrow_mask (
    input  wire logic            clk_in,
    input  wire logic            rst_in,
    input  wire logic            hit_valid,
    input  wire pix_pkg::vec3_t  hit,
    input  wire pix_pkg::vec3_t  block_pos,
    input  wire pix_pkg::dir_e   dir,
    input  wire pix_pkg::coord_t arrow_half,
    input  wire pix_pkg::coord_t face_height,
    output logic                 on_arrow,
    output logic                 arrow_valid
);

    pix_pkg::vec3_t  rel;
    pix_pkg::dir_e   rel_dir;
    logic            rel_valid;

    pix_pkg::coord_t abs_x;
    pix_pkg::coord_t abs_y;
    logic            face_ok;
    logic            bounds_ok;
    logic            tri_ok;

    ////////////////////////////////////////
    // stage 1 hit relative to the block
    ////////////////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            rel_valid <= 1'b0;
        end else begin
            rel_valid <= hit_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        rel.x   <= hit.x - block_pos.x;
        rel.y   <= hit.y - block_pos.y;
        rel.z   <= hit.z - block_pos.z;
        rel_dir <= dir;
    end

    ////////////////////////////////////////
    // stage 2 arrow rule
    ////////////////////////////////////////

    always_comb begin
        abs_x = (rel.x < 0) ? -rel.x : rel.x;
        abs_y = (rel.y < 0) ? -rel.y : rel.y;

        // only the top face carries the arrow
        face_ok   = rel.z <= face_height;
        bounds_ok = (abs_x < arrow_half) && (abs_y < arrow_half);

        // triangle pointing the way of the arrow
        case (rel_dir)
            pix_pkg::DIR_UP:    tri_ok = (rel.y > 0) && (abs_y >= abs_x);
            pix_pkg::DIR_DOWN:  tri_ok = (rel.y < 0) && (abs_y >= abs_x);
            pix_pkg::DIR_LEFT:  tri_ok = (rel.x < 0) && (abs_x >= abs_y);
            pix_pkg::DIR_RIGHT: tri_ok = (rel.x > 0) && (abs_x >= abs_y);
            default:            tri_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            arrow_valid <= 1'b0;
        end else begin
            arrow_valid <= rel_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        on_arrow <= face_ok && bounds_ok && tri_ok;
    end

endmodule

`default_nettype wire

/* src/pixel_shader.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_shader (
    input  wire logic            clk_in,
    input  wire logic            rst_in,
    input  wire logic            arrow_valid,
    input  wire logic            on_arrow,
    input  wire pix_pkg::color_e color,
    input  wire pix_pkg::coord_t intensity,
    output pix_pkg::rgb_t        rgb,
    output logic                 rgb_valid
);

    pix_pkg::rgb_t   base;
    pix_pkg::coord_t brightest;

    always_comb begin
        // material picks the lit channel
        base.r = (color == pix_pkg::COLOR_RED)  ? intensity : '0;
        base.g = '0;
        base.b = (color == pix_pkg::COLOR_BLUE) ? intensity : '0;

        brightest = base.r;
        if (base.g > brightest) begin
            brightest = base.g;
        end
        if (base.b > brightest) begin
            brightest = base.b;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            rgb_valid <= 1'b0;
        end else begin
            rgb_valid <= arrow_valid;
        end
    end

    // grey override for arrow pixels
    always_ff @(posedge clk_in) begin
        if (arrow_valid) begin
            rgb <= on_arrow ? '{r: brightest, g: brightest, b: brightest} : base;
        end
    end

endmodule

`default_nettype wire

/* src/pixel_color_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_color_top #(
    parameter int BLOCK_DELAY = 2,
    parameter int COLOR_DELAY = 4
) (
    input  wire logic             clk_in,
    input  wire logic             rst_in,
    input  wire pix_pkg::wb_req_t wb_req,
    output pix_pkg::wb_rsp_t      wb_rsp,
    input  wire logic             valid_in,
    input  wire pix_pkg::vec3_t   ray,
    input  wire pix_pkg::coord_t  t,
    input  wire pix_pkg::block_t  block,
    output pix_pkg::rgb_t         rgb,
    output logic                  rgb_valid
);

    // position and direction travel together
    localparam int DIR_W = $bits(pix_pkg::dir_e);
    localparam int BLK_W = $bits(pix_pkg::vec3_t) + DIR_W;

    pix_pkg::cfg_t  cfg;
    pix_pkg::vec3_t hit;
    logic           hit_valid;
    logic           on_arrow;
    logic           arrow_valid;
    logic [BLK_W-1:0] blk_d;
    logic             color_d;

    pix_cfg_regs i_cfg_regs (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .cfg    (cfg)
    );

    ////////////////////////////////////////
    // pixel pipeline
    ////////////////////////////////////////

    hit_point_calc i_hit_point (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .valid_in  (valid_in),
        .ray       (ray),
        .t         (t),
        .eye       (cfg.eye),
        .hit       (hit),
        .hit_valid (hit_valid)
    );

    // block data waits for the hit point
    delay_line #(
        .WIDTH (BLK_W),
        .DEPTH (BLOCK_DELAY)
    ) i_block_delay (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .din    ({block.pos, block.dir}),
        .dout   (blk_d)
    );

    arrow_mask i_arrow_mask (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .hit_valid   (hit_valid),
        .hit         (hit),
        .block_pos   (blk_d[DIR_W +: $bits(pix_pkg::vec3_t)]),
        .dir         (pix_pkg::dir_e'(blk_d[DIR_W-1:0])),
        .arrow_half  (cfg.arrow_half),
        .face_height (cfg.face_height),
        .on_arrow    (on_arrow),
        .arrow_valid (arrow_valid)
    );

    // colour waits for the arrow flag
    delay_line #(
        .WIDTH (1),
        .DEPTH (COLOR_DELAY)
    ) i_color_delay (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .din    (block.color),
        .dout   (color_d)
    );

    pixel_shader i_shader (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .arrow_valid (arrow_valid),
        .on_arrow    (on_arrow),
        .color       (pix_pkg::color_e'(color_d)),
        .intensity   (cfg.intensity),
        .rgb         (rgb),
        .rgb_valid   (rgb_valid)
    );

endmodule

`default_nettype wire

/* verif/tb_pixel_color.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pixel_color;

    localparam int CLK_PERIOD = 40;
    localparam int N_RANDOM   = 200;
    // wishbone accesses, three directed sets and the random stream
    localparam int N_TXN      = 33 + 3 * 13 + N_RANDOM;
    localparam pix_pkg::coord_t ONE = 32'sh0001_0000;
    localparam pix_pkg::coord_t CFG_DEFAULT [6] = '{
        1800 * ONE, 1800 * ONE, -300 * ONE, 80 * ONE, 200 * ONE, ONE
    };

    typedef struct packed {
        int            due;
        pix_pkg::rgb_t rgb;
    } expect_t;

    logic             clk_in;
    logic             rst_in;
    pix_pkg::wb_req_t wb_req;
    pix_pkg::wb_rsp_t wb_rsp;
    logic             valid_in;
    pix_pkg::vec3_t   ray;
    pix_pkg::coord_t  t;
    pix_pkg::block_t  block;
    pix_pkg::rgb_t    rgb;
    logic             rgb_valid;

    expect_t          pending[$];
    pix_pkg::coord_t  cfg_mirror [6];
    logic [31:0]      lfsr;
    int               cycle = 0;

    pixel_color_top #(
        .BLOCK_DELAY (2),
        .COLOR_DELAY (4)
    ) i_dut (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .valid_in  (valid_in),
        .ray       (ray),
        .t         (t),
        .block     (block),
        .rgb       (rgb),
        .rgb_valid (rgb_valid)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    always @(posedge clk_in) cycle <= cycle + 1;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    ////////////////////////////////////////
    // random numbers and reference model
    ////////////////////////////////////////

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // signed value in [-2^(n-1), 2^(n-1))
    function automatic pix_pkg::coord_t srand(input int n);
        return $signed(rand_bits(n)) - (32'sd1 <<< (n - 1));
    endfunction

    function automatic pix_pkg::coord_t qmul(input pix_pkg::coord_t a, input pix_pkg::coord_t b);
        longint p;
        p = longint'(a) * longint'(b);
        p = p >>> pix_pkg::FRAC_BITS;
        return pix_pkg::coord_t'(p);
    endfunction

    function automatic pix_pkg::rgb_t model_pixel(input pix_pkg::vec3_t r,
                                                  input pix_pkg::coord_t tt,
                                                  input pix_pkg::block_t b);
        pix_pkg::coord_t x;
        pix_pkg::coord_t y;
        pix_pkg::coord_t z;
        pix_pkg::coord_t ax;
        pix_pkg::coord_t ay;
        pix_pkg::coord_t top;
        logic            on;
        pix_pkg::rgb_t   c;
        x  = cfg_mirror[0] + qmul(tt, r.x) - b.pos.x;
        y  = cfg_mirror[1] + qmul(tt, r.y) - b.pos.y;
        z  = cfg_mirror[2] + qmul(tt, r.z) - b.pos.z;
        ax = (x < 0) ? -x : x;
        ay = (y < 0) ? -y : y;
        case (b.dir)
            pix_pkg::DIR_UP:   on = (y > 0) && (y >= ax);
            pix_pkg::DIR_DOWN: on = (y < 0) && (-y >= ax);
            pix_pkg::DIR_LEFT: on = (x < 0) && (-x >= ay);
            default:           on = (x > 0) && (x >= ay);
        endcase
        on = on && (z <= cfg_mirror[4]) && (ax < cfg_mirror[3]) && (ay < cfg_mirror[3]);
        c = '0;
        if (b.color == pix_pkg::COLOR_RED) c.r = cfg_mirror[5];
        else c.b = cfg_mirror[5];
        if (on) begin
            // green is always zero, so it takes part as a floor
            top = (c.r > c.b) ? c.r : c.b;
            if (top < 0) top = '0;
            c = '{r: top, g: top, b: top};
        end
        return c;
    endfunction

    ////////////////////////////////////////
    // wishbone master
    ////////////////////////////////////////

    task automatic wb_access(input logic we, input pix_pkg::wb_adr_t adr,
                             input pix_pkg::coord_t dat, output pix_pkg::coord_t rd);
        @(negedge clk_in);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        @(negedge clk_in);
        assert (wb_rsp.ack) else stop_on_error(
            $sformatf("CHECK FAILED at %0t: wb_rsp.ack expected 1 got 0", $time));
        rd = wb_rsp.dat;
        wb_req = '0;
        if (we && adr < 3'd6) cfg_mirror[adr] = dat;
        @(negedge clk_in);
        assert (!wb_rsp.ack) else stop_on_error(
            $sformatf("CHECK FAILED at %0t: wb_rsp.ack expected 0 got 1", $time));
    endtask

    task automatic write_reg(input pix_pkg::wb_adr_t adr, input pix_pkg::coord_t dat);
        pix_pkg::coord_t ignored;
        wb_access(1'b1, adr, dat, ignored);
    endtask

    task automatic read_check(input pix_pkg::wb_adr_t adr);
        pix_pkg::coord_t rd;
        pix_pkg::coord_t exp;
        exp = (adr < 3'd6) ? cfg_mirror[adr] : '0;
        wb_access(1'b0, adr, '0, rd);
        assert (rd == exp) else stop_on_error($sformatf(
            "CHECK FAILED at %0t: wb_rsp.dat (adr %0d) expected %h got %h", $time, adr, exp, rd));
    endtask

    ////////////////////////////////////////
    // pixel stimulus
    ////////////////////////////////////////

    task automatic send_pixel(input pix_pkg::vec3_t r, input pix_pkg::coord_t tt,
                              input pix_pkg::block_t b);
        expect_t e;
        @(negedge clk_in);
        valid_in = 1'b1;
        ray      = r;
        t        = tt;
        block    = b;
        e.due    = cycle + 5;
        e.rgb    = model_pixel(r, tt, b);
        pending.push_back(e);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk_in);
            valid_in = 1'b0;
        end
    endtask

    task automatic drain();
        while (pending.size() != 0) @(negedge clk_in);
    endtask

    // aim a fixed ray so that the hit lands at rel from the block
    task automatic send_rel(input pix_pkg::vec3_t aim, input pix_pkg::vec3_t rel,
                            input pix_pkg::dir_e dir, input pix_pkg::color_e color);
        pix_pkg::vec3_t  r;
        pix_pkg::block_t b;
        r = '{x: 100 * ONE, y: -50 * ONE, z: 250 * ONE};
        b.pos.x = aim.x + r.x - rel.x;
        b.pos.y = aim.y + r.y - rel.y;
        b.pos.z = aim.z + r.z - rel.z;
        b.dir   = dir;
        b.color = color;
        send_pixel(r, ONE, b);
    endtask

    task automatic directed_set(input pix_pkg::vec3_t aim);
        pix_pkg::vec3_t p;
        for (int d = 0; d < 4; d++) begin
            // d runs up, right, down, left
            p.x = (d == 1) ? 30 * ONE : (d == 3) ? -30 * ONE : 0;
            p.y = (d == 0) ? 30 * ONE : (d == 2) ? -30 * ONE : 0;
            p.z = d * 50 * ONE;
            send_rel(aim, p, pix_pkg::dir_e'(d[1:0]), pix_pkg::color_e'(d[0]));
            // opposite triangle
            p.x = -p.x;
            p.y = -p.y;
            send_rel(aim, p, pix_pkg::dir_e'(d[1:0]), pix_pkg::color_e'(~d[0]));
        end
        // one lsb above the face, then on the face edge and around the bounds
        send_rel(aim, '{x: 0, y: 30 * ONE, z: cfg_mirror[4] + 1}, pix_pkg::DIR_UP,
                 pix_pkg::COLOR_RED);
        send_rel(aim, '{x: 0, y: 30 * ONE, z: cfg_mirror[4]}, pix_pkg::DIR_UP,
                 pix_pkg::COLOR_BLUE);
        send_rel(aim, '{x: 0, y: cfg_mirror[3], z: 0}, pix_pkg::DIR_UP, pix_pkg::COLOR_BLUE);
        send_rel(aim, '{x: -cfg_mirror[3] - ONE, y: 0, z: 0}, pix_pkg::DIR_LEFT,
                 pix_pkg::COLOR_RED);
        send_rel(aim, '{x: 0, y: -20 * ONE, z: -ONE}, pix_pkg::DIR_DOWN, pix_pkg::COLOR_RED);
        idle_cycles(1);
    endtask

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    assert property (@(posedge clk_in) disable iff (rst_in) wb_rsp.ack |=> !wb_rsp.ack)
        else stop_on_error($sformatf("CHECK FAILED at %0t: wb_rsp.ack expected 0 got 1", $time));

    assert property (@(posedge clk_in) disable iff (rst_in)
                     wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else stop_on_error("ack was raised without a bus request");

    // every result answers the input five cycles before it
    assert property (@(posedge clk_in) disable iff (rst_in || cycle < 8)
                     rgb_valid == $past(valid_in, 5))
        else stop_on_error($sformatf("CHECK FAILED at %0t: rgb_valid expected %b got %b",
                                     $time, !rgb_valid, rgb_valid));

    always @(negedge clk_in) begin
        expect_t e;
        if (rgb_valid) begin
            assert (pending.size() != 0)
                else stop_on_error("rgb_valid was high with no pixel in flight");
            e = pending.pop_front();
            assert (e.due == cycle) else stop_on_error($sformatf(
                "pixel arrived at cycle %0d but was due at cycle %0d", cycle, e.due));
            assert (rgb == e.rgb) else stop_on_error($sformatf(
                "CHECK FAILED at %0t: rgb expected %h got %h", $time, e.rgb, rgb));
        end
    end

    initial begin
        #(CLK_PERIOD * (N_TXN * 10 + 200));
        stop_on_error("watchdog expired before the tests finished");
    end

    initial begin
        pix_pkg::vec3_t  r;
        pix_pkg::vec3_t  rel;
        pix_pkg::coord_t tt;
        pix_pkg::block_t b;
        logic [31:0]     rb;
        lfsr       = 32'h9dab_bc76;
        cfg_mirror = CFG_DEFAULT;
        rst_in     = 1'b1;
        valid_in   = 1'b0;
        ray        = '0;
        t          = '0;
        block      = '0;
        wb_req     = '0;
        repeat (3) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;

        // reset state and register values
        assert (!rgb_valid) else stop_on_error($sformatf(
            "CHECK FAILED at %0t: rgb_valid expected 0 got %b", $time, rgb_valid));
        assert (!wb_rsp.ack) else stop_on_error($sformatf(
            "CHECK FAILED at %0t: wb_rsp.ack expected 0 got %b", $time, wb_rsp.ack));
        for (int a = 0; a < 6; a++) read_check(pix_pkg::wb_adr_t'(a));

        // write and read back, including the two unmapped addresses
        for (int a = 0; a < 8; a++) begin
            write_reg(pix_pkg::wb_adr_t'(a), srand(31));
            read_check(pix_pkg::wb_adr_t'(a));
        end
        for (int a = 0; a < 6; a++) write_reg(pix_pkg::wb_adr_t'(a), CFG_DEFAULT[a]);

        // material colour and arrow directions
        directed_set('{x: CFG_DEFAULT[0], y: CFG_DEFAULT[1], z: CFG_DEFAULT[2]});
        drain();

        ////////////////////////////////////////
        // random stream, back to back and with gaps
        ////////////////////////////////////////
        repeat (N_RANDOM) begin
            r   = '{x: srand(24), y: srand(24), z: srand(24)};
            tt  = ONE / 2 + rand_bits(17);
            rel = '{x: srand(24), y: srand(24), z: srand(25)};
            b.pos.x = cfg_mirror[0] + qmul(tt, r.x) - rel.x;
            b.pos.y = cfg_mirror[1] + qmul(tt, r.y) - rel.y;
            b.pos.z = cfg_mirror[2] + qmul(tt, r.z) - rel.z;
            rb      = rand_bits(3);
            b.dir   = pix_pkg::dir_e'(rb[1:0]);
            b.color = pix_pkg::color_e'(rb[2]);
            send_pixel(r, tt, b);
            if (rand_bits(1) != 0) idle_cycles(1 + int'(rand_bits(2)));
        end
        idle_cycles(1);
        drain();

        // new eye, arrow size and intensity on an idle pipeline
        write_reg(pix_pkg::REG_EYE_X, 1500 * ONE);
        write_reg(pix_pkg::REG_EYE_Y, 2100 * ONE);
        write_reg(pix_pkg::REG_EYE_Z, -250 * ONE);
        write_reg(pix_pkg::REG_ARROW_HALF, 40 * ONE);
        write_reg(pix_pkg::REG_INTENSITY, ONE / 4 * 3);
        directed_set('{x: CFG_DEFAULT[0], y: CFG_DEFAULT[1], z: CFG_DEFAULT[2]});
        directed_set('{x: cfg_mirror[0], y: cfg_mirror[1], z: cfg_mirror[2]});
        drain();

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
src/pix_pkg.sv
src/pix_cfg_regs.sv
src/delay_line.sv
src/hit_point_calc.sv
src/arrow_mask.sv
src/pixel_shader.sv
src/pixel_color_top.sv
verif/tb_pixel_color.sv

/* run_sim.sh */
#!/bin/sh
# build and run the pixel colour testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f list.f \
    --top-module tb_pixel_color \
    -o sim_pixel_color

./obj_dir/sim_pixel_color | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
